// ==== hw/isaPkg.sv ====
package isaPkg;

	// Raw instruction byte as read from instruction memory
	typedef logic [7:0] opcodeT;

	// Entry states carry the code of their opcode, so fetch2 can load the
	// byte straight into the state register. Follow-on states sit in the
	// 8'hc0 to 8'hf1 range, which no opcode uses
	typedef enum logic [7:0] {
		endOp       = 8'h00,
		rstAll      = 8'h01,
		rstAc       = 8'h02,
		rstAddr     = 8'h03,
		rstGsp      = 8'h04,
		rstMc       = 8'h05,
		rstCp       = 8'h06,
		rstRp       = 8'h07,
		incGsp      = 8'h08,
		incAc       = 8'h09,
		incCp       = 8'h0a,
		incRp       = 8'h0b,
		incMc       = 8'h0c,
		incStp      = 8'h0d,
		ldAddr1     = 8'h10,
		ldAc1       = 8'h11,
		ldMulr1     = 8'h12,
		ldRp1       = 8'h13,
		ldCp1       = 8'h14,
		store       = 8'h15,
		add         = 8'h20,
		mul1        = 8'h21,
		mul2        = 8'h22,
		div         = 8'h23,
		mod         = 8'h24,
		jmpZ1       = 8'h30,
		jmpZ2       = 8'h31,
		jump1       = 8'h32,
		// Second halves of loads and store
		ldAddr2     = 8'hc0,
		ldAc2       = 8'hc1,
		ldMulr2     = 8'hc2,
		ldRp2       = 8'hc3,
		ldCp2       = 8'hc4,
		storeWrite  = 8'hc5,
		// Branch and jump steps
		jmpZ1Taken1 = 8'hd0,
		jmpZ1Taken2 = 8'hd1,
		jmpZ1Taken3 = 8'hd2,
		jmpZ1Skip1  = 8'hd3,
		jmpZ1Skip2  = 8'hd4,
		jmpZ2Taken1 = 8'hd8,
		jmpZ2Taken2 = 8'hd9,
		jmpZ2Taken3 = 8'hda,
		jmpZ2Skip1  = 8'hdb,
		jmpZ2Skip2  = 8'hdc,
		jump2       = 8'he0,
		jump3       = 8'he1,
		jump4       = 8'he2,
		fetch1      = 8'hf0,
		fetch2      = 8'hf1
	} sequencerStateT;

endpackage

// ==== hw/controlPkg.sv ====
package controlPkg;

	// ALU operation field
	typedef logic [2:0] aluOpT;
	localparam aluOpT aluNone = 3'd0;
	localparam aluOpT aluAdd  = 3'd1;
	localparam aluOpT aluMul  = 3'd2;
	localparam aluOpT aluDiv  = 3'd3;
	localparam aluOpT aluMod  = 3'd4;

	// Source driving the shared datapath bus
	typedef logic [3:0] busSelectT;
	localparam busSelectT busAc     = 4'd0;
	localparam busSelectT busMemOut = 4'd1;
	localparam busSelectT busAddr   = 4'd2;
	localparam busSelectT busMulr   = 4'd3;
	localparam busSelectT busMv     = 4'd4;
	localparam busSelectT busWv     = 4'd5;

	// Pointer register that forms the memory address
	typedef logic [1:0] addressPathT;
	localparam addressPathT pathGsp = 2'd0;
	localparam addressPathT pathStp = 2'd1;
	localparam addressPathT pathRp  = 2'd2;
	localparam addressPathT pathCp  = 2'd3;

	typedef logic [1:0] memControlT;
	localparam memControlT memIdle  = 2'd0;
	localparam memControlT memRead  = 2'd1;
	localparam memControlT memWrite = 2'd2;

	// One bit per datapath register, positions below
	localparam int regCount = 14;
	typedef logic [regCount-1:0] registerMaskT;

	localparam int regPc   = 0;
	localparam int regIr   = 1;
	localparam int regGsp  = 2;
	localparam int regRp   = 3;
	localparam int regCp   = 4;
	localparam int regStp  = 5;
	localparam int regCid  = 6;
	localparam int regEopc = 7;
	localparam int regMc   = 8;
	localparam int regMv   = 9;
	localparam int regWv   = 10;
	localparam int regMulr = 11;
	localparam int regAddr = 12;
	localparam int regAc   = 13;

endpackage

// ==== hw/stateSequencer.sv ====
module stateSequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  isaPkg::opcodeT         instruction,
	input  logic                   zeroFlag1,
	input  logic                   zeroFlag2,
	output isaPkg::sequencerStateT state
);

	isaPkg::sequencerStateT nextState;

	always_comb begin
		// Single-state instructions and last steps go back to fetch
		nextState = isaPkg::fetch1;
		case (state)
			isaPkg::fetch1: nextState = isaPkg::fetch2;
			isaPkg::fetch2: begin
				// Dispatch on the fetched byte, unknown codes refetch
				case (instruction)
					isaPkg::endOp,
					isaPkg::rstAll, isaPkg::rstAc, isaPkg::rstAddr, isaPkg::rstGsp,
					isaPkg::rstMc, isaPkg::rstCp, isaPkg::rstRp,
					isaPkg::incGsp, isaPkg::incAc, isaPkg::incCp, isaPkg::incRp,
					isaPkg::incMc, isaPkg::incStp,
					isaPkg::ldAddr1, isaPkg::ldAc1, isaPkg::ldMulr1, isaPkg::ldRp1,
					isaPkg::ldCp1, isaPkg::store,
					isaPkg::add, isaPkg::mul1, isaPkg::mul2, isaPkg::div, isaPkg::mod,
					isaPkg::jmpZ1, isaPkg::jmpZ2, isaPkg::jump1:
						nextState = isaPkg::sequencerStateT'(instruction);
					default:
						nextState = isaPkg::fetch1;
				endcase
			end

			// Halt holds until reset
			isaPkg::endOp: nextState = isaPkg::endOp;

			isaPkg::ldAddr1: nextState = isaPkg::ldAddr2;
			isaPkg::ldAc1:   nextState = isaPkg::ldAc2;
			isaPkg::ldMulr1: nextState = isaPkg::ldMulr2;
			isaPkg::ldRp1:   nextState = isaPkg::ldRp2;
			isaPkg::ldCp1:   nextState = isaPkg::ldCp2;
			isaPkg::store:   nextState = isaPkg::storeWrite;

			// Z1 branch is taken on a set flag
			isaPkg::jmpZ1: begin
				if (zeroFlag1) begin
					nextState = isaPkg::jmpZ1Taken1;
				end else begin
					nextState = isaPkg::jmpZ1Skip1;
				end
			end
			isaPkg::jmpZ1Taken1: nextState = isaPkg::jmpZ1Taken2;
			isaPkg::jmpZ1Taken2: nextState = isaPkg::jmpZ1Taken3;
			isaPkg::jmpZ1Skip1:  nextState = isaPkg::jmpZ1Skip2;

			// Z2 branch is taken on a clear flag
			isaPkg::jmpZ2: begin
				if (!zeroFlag2) begin
					nextState = isaPkg::jmpZ2Taken1;
				end else begin
					nextState = isaPkg::jmpZ2Skip1;
				end
			end
			isaPkg::jmpZ2Taken1: nextState = isaPkg::jmpZ2Taken2;
			isaPkg::jmpZ2Taken2: nextState = isaPkg::jmpZ2Taken3;
			isaPkg::jmpZ2Skip1:  nextState = isaPkg::jmpZ2Skip2;

			isaPkg::jump1: nextState = isaPkg::jump2;
			isaPkg::jump2: nextState = isaPkg::jump3;
			isaPkg::jump3: nextState = isaPkg::jump4;

			default: nextState = isaPkg::fetch1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= isaPkg::fetch1;
		end else begin
			state <= nextState;
		end
	end

endmodule

// ==== hw/controlDecoder.sv ====
module controlDecoder (
	input  logic                       clk,
	input  logic                       reset,
	input  isaPkg::sequencerStateT     state,
	output controlPkg::aluOpT          aluOp,
	output controlPkg::busSelectT      busSelect,
	output controlPkg::addressPathT    addressPath,
	output controlPkg::memControlT     memControl,
	output controlPkg::registerMaskT   writeEnable,
	output controlPkg::registerMaskT   incrementEnable,
	output controlPkg::registerMaskT   resetEnable
);

	// One-hot mask for a single register position
	function automatic controlPkg::registerMaskT regBit(input int position);
		return controlPkg::registerMaskT'(1) << position;
	endfunction

	// Everything except PC and IR
	localparam controlPkg::registerMaskT clearAllMask =
		regBit(controlPkg::regGsp) | regBit(controlPkg::regRp) |
		regBit(controlPkg::regCp) | regBit(controlPkg::regStp) |
		regBit(controlPkg::regCid) | regBit(controlPkg::regEopc) |
		regBit(controlPkg::regMc) | regBit(controlPkg::regMv) |
		regBit(controlPkg::regWv) | regBit(controlPkg::regMulr) |
		regBit(controlPkg::regAddr) | regBit(controlPkg::regAc);

	controlPkg::aluOpT        nextAluOp;
	controlPkg::busSelectT    nextBusSelect;
	controlPkg::addressPathT  nextAddressPath;
	controlPkg::memControlT   nextMemControl;
	controlPkg::registerMaskT nextWrite;
	controlPkg::registerMaskT nextIncrement;
	controlPkg::registerMaskT nextReset;

	always_comb begin
		// Idle word, overridden below per state
		nextAluOp       = controlPkg::aluNone;
		nextBusSelect   = controlPkg::busAc;
		nextAddressPath = controlPkg::pathGsp;
		nextMemControl  = controlPkg::memIdle;
		nextWrite       = '0;
		nextIncrement   = '0;
		nextReset       = '0;

		case (state)
			isaPkg::fetch1: nextAddressPath = controlPkg::pathStp;
			isaPkg::fetch2: begin
				nextIncrement = regBit(controlPkg::regPc);
				nextWrite     = regBit(controlPkg::regIr);
			end

			isaPkg::rstAll:  nextReset = clearAllMask;
			isaPkg::rstAc:   nextReset = regBit(controlPkg::regAc);
			isaPkg::rstAddr: nextReset = regBit(controlPkg::regAddr);
			isaPkg::rstGsp:  nextReset = regBit(controlPkg::regGsp);
			isaPkg::rstMc:   nextReset = regBit(controlPkg::regMc);
			isaPkg::rstCp:   nextReset = regBit(controlPkg::regCp);
			isaPkg::rstRp:   nextReset = regBit(controlPkg::regRp);

			isaPkg::incGsp: nextIncrement = regBit(controlPkg::regGsp);
			isaPkg::incAc:  nextIncrement = regBit(controlPkg::regAc);
			isaPkg::incCp:  nextIncrement = regBit(controlPkg::regCp);
			isaPkg::incRp:  nextIncrement = regBit(controlPkg::regRp);
			isaPkg::incMc:  nextIncrement = regBit(controlPkg::regMc);
			isaPkg::incStp: nextIncrement = regBit(controlPkg::regStp);

			// Load first halves read memory through GSP unless noted
			isaPkg::ldAddr1, isaPkg::ldAc1, isaPkg::ldMulr1:
				nextMemControl = controlPkg::memRead;
			isaPkg::ldRp1: begin
				nextMemControl  = controlPkg::memRead;
				nextAddressPath = controlPkg::pathRp;
			end
			isaPkg::ldCp1: begin
				nextMemControl  = controlPkg::memRead;
				nextAddressPath = controlPkg::pathCp;
			end

			// Second halves latch memory output into the target
			isaPkg::ldAddr2: begin
				nextBusSelect = controlPkg::busMemOut;
				nextWrite     = regBit(controlPkg::regAddr);
			end
			isaPkg::ldAc2, isaPkg::ldCp2: begin
				nextBusSelect = controlPkg::busMemOut;
				nextWrite     = regBit(controlPkg::regAc);
			end
			isaPkg::ldMulr2, isaPkg::ldRp2: begin
				nextBusSelect = controlPkg::busMemOut;
				nextWrite     = regBit(controlPkg::regMulr);
			end

			isaPkg::store: nextAddressPath = controlPkg::pathStp;
			isaPkg::storeWrite: begin
				nextAddressPath = controlPkg::pathStp;
				nextMemControl  = controlPkg::memWrite;
			end

			isaPkg::add: begin
				nextAluOp     = controlPkg::aluAdd;
				nextBusSelect = controlPkg::busAddr;
			end
			isaPkg::mul1: begin
				nextAluOp     = controlPkg::aluMul;
				nextBusSelect = controlPkg::busMulr;
			end
			isaPkg::mul2: begin
				nextAluOp     = controlPkg::aluMul;
				nextBusSelect = controlPkg::busMv;
			end
			isaPkg::div: begin
				nextAluOp     = controlPkg::aluDiv;
				nextBusSelect = controlPkg::busWv;
			end
			isaPkg::mod: begin
				nextAluOp     = controlPkg::aluMod;
				nextBusSelect = controlPkg::busWv;
			end

			// Taken branch reloads IR, then PC
			isaPkg::jmpZ1Taken1, isaPkg::jmpZ2Taken1:
				nextWrite = regBit(controlPkg::regIr);
			isaPkg::jmpZ1Taken2, isaPkg::jmpZ2Taken2, isaPkg::jump3:
				nextWrite = regBit(controlPkg::regPc);
			// Skip steps past the target operand
			isaPkg::jmpZ1Skip1, isaPkg::jmpZ2Skip1: begin
				nextIncrement = regBit(controlPkg::regPc);
				nextWrite     = regBit(controlPkg::regIr);
			end

			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			aluOp           <= controlPkg::aluNone;
			busSelect       <= controlPkg::busAc;
			addressPath     <= controlPkg::pathGsp;
			memControl      <= controlPkg::memIdle;
			writeEnable     <= '0;
			incrementEnable <= '0;
			resetEnable     <= '0;
		end else begin
			aluOp           <= nextAluOp;
			busSelect       <= nextBusSelect;
			addressPath     <= nextAddressPath;
			memControl      <= nextMemControl;
			writeEnable     <= nextWrite;
			incrementEnable <= nextIncrement;
			resetEnable     <= nextReset;
		end
	end

endmodule

// ==== hw/controlUnit.sv ====
module controlUnit (
	input  logic                       clk,
	input  logic                       reset,
	input  isaPkg::opcodeT             instruction,
	input  logic                       zeroFlag1,
	input  logic                       zeroFlag2,
	output controlPkg::aluOpT          aluOp,
	output controlPkg::busSelectT      busSelect,
	output controlPkg::addressPathT    addressPath,
	output controlPkg::memControlT     memControl,
	output controlPkg::registerMaskT   writeEnable,
	output controlPkg::registerMaskT   incrementEnable,
	output controlPkg::registerMaskT   resetEnable
);

	// Current microstate, its control word shows up one cycle later
	isaPkg::sequencerStateT state;

	stateSequencer sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.zeroFlag1   (zeroFlag1),
		.zeroFlag2   (zeroFlag2),
		.state       (state)
	);

	controlDecoder decoder_i (
		.clk             (clk),
		.reset           (reset),
		.state           (state),
		.aluOp           (aluOp),
		.busSelect       (busSelect),
		.addressPath     (addressPath),
		.memControl      (memControl),
		.writeEnable     (writeEnable),
		.incrementEnable (incrementEnable),
		.resetEnable     (resetEnable)
	);

endmodule

// ==== verification/clockGen.sv ====
module clockGen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset spans the first eight rising edges, released like any other input
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#5 reset = 1'b0;
	end

endmodule

// ==== verification/controlUnitTb.sv ====
module controlUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	// One control word, a field per DUT output
	typedef struct packed {
		controlPkg::aluOpT        alu;
		controlPkg::busSelectT    bus;
		controlPkg::addressPathT  path;
		controlPkg::memControlT   mem;
		controlPkg::registerMaskT wr;
		controlPkg::registerMaskT inc;
		controlPkg::registerMaskT clr;
	} wordT;

	localparam wordT idleWord = '{controlPkg::aluNone, controlPkg::busAc,
		controlPkg::pathGsp, controlPkg::memIdle, '0, '0, '0};

	// Program length, test by test in the order of the initial block
	localparam int programCycles = 3 + 13 * 3 + 6 * 4 + 5 * 3
		+ (6 + 5 + 6 + 5 + 6) + (2 + 2 + 10);
	localparam int cycleLimit = programCycles + 8 + 20;

	logic clk;
	logic reset;
	isaPkg::opcodeT instruction;
	logic zeroFlag1;
	logic zeroFlag2;
	controlPkg::aluOpT aluOp;
	controlPkg::busSelectT busSelect;
	controlPkg::addressPathT addressPath;
	controlPkg::memControlT memControl;
	controlPkg::registerMaskT writeEnable;
	controlPkg::registerMaskT incrementEnable;
	controlPkg::registerMaskT resetEnable;

	wordT want;
	isaPkg::opcodeT curOp = '0;
	int step = 0;
	bit taken = 1'b0;
	int testIndex = 0;
	int checkIndex = 0;
	int cycleCount = 0;
	int errorCount = 0;
	int testErrors[6] = '{0, 0, 0, 0, 0, 0};
	string testNames[6] = '{"reset and fetch", "clears and increments", "loads and store",
		"alu operations", "jumps", "unknown byte and halt"};

	clockGen clockGen_i (.clk(clk), .reset(reset));

	controlUnit controlUnit_i (.*);

	function automatic controlPkg::registerMaskT maskOf(input int position);
		controlPkg::registerMaskT m;
		m = '0;
		m[4'(position)] = 1'b1;
		return m;
	endfunction

	// Cycles from fetch1 to the next fetch1, bytes outside the ISA only fetch
	function automatic int instrLength(input isaPkg::opcodeT op, input bit isTaken);
		case (op)
			isaPkg::ldAddr1, isaPkg::ldAc1, isaPkg::ldMulr1, isaPkg::ldRp1, isaPkg::ldCp1,
			isaPkg::store:
				return 4;
			isaPkg::jmpZ1, isaPkg::jmpZ2:
				return isTaken ? 6 : 5;
			isaPkg::jump1:
				return 6;
			isaPkg::endOp, isaPkg::rstAll, isaPkg::rstAc, isaPkg::rstAddr, isaPkg::rstGsp,
			isaPkg::rstMc, isaPkg::rstCp, isaPkg::rstRp, isaPkg::incGsp, isaPkg::incAc,
			isaPkg::incCp, isaPkg::incRp, isaPkg::incMc, isaPkg::incStp, isaPkg::add,
			isaPkg::mul1, isaPkg::mul2, isaPkg::div, isaPkg::mod:
				return 3;
			default:
				return 2;
		endcase
	endfunction

	// Word for step n of an instruction, step 0 being fetch1
	function automatic wordT wordFor(input isaPkg::opcodeT op, input int n, input bit isTaken);
		wordT w;
		w = idleWord;
		if (n == 0) begin
			w.path = controlPkg::pathStp;
		end else if (n == 1) begin
			w.inc = maskOf(controlPkg::regPc);
			w.wr = maskOf(controlPkg::regIr);
		end else if (n == 2) begin
			case (op)
				isaPkg::rstAll: w.clr = ~(maskOf(controlPkg::regPc) | maskOf(controlPkg::regIr));
				isaPkg::rstAc: w.clr = maskOf(controlPkg::regAc);
				isaPkg::rstAddr: w.clr = maskOf(controlPkg::regAddr);
				isaPkg::rstGsp: w.clr = maskOf(controlPkg::regGsp);
				isaPkg::rstMc: w.clr = maskOf(controlPkg::regMc);
				isaPkg::rstCp: w.clr = maskOf(controlPkg::regCp);
				isaPkg::rstRp: w.clr = maskOf(controlPkg::regRp);
				isaPkg::incGsp: w.inc = maskOf(controlPkg::regGsp);
				isaPkg::incAc: w.inc = maskOf(controlPkg::regAc);
				isaPkg::incCp: w.inc = maskOf(controlPkg::regCp);
				isaPkg::incRp: w.inc = maskOf(controlPkg::regRp);
				isaPkg::incMc: w.inc = maskOf(controlPkg::regMc);
				isaPkg::incStp: w.inc = maskOf(controlPkg::regStp);
				isaPkg::ldAddr1, isaPkg::ldAc1, isaPkg::ldMulr1: w.mem = controlPkg::memRead;
				isaPkg::ldRp1: begin
					w.mem = controlPkg::memRead;
					w.path = controlPkg::pathRp;
				end
				isaPkg::ldCp1: begin
					w.mem = controlPkg::memRead;
					w.path = controlPkg::pathCp;
				end
				isaPkg::store: w.path = controlPkg::pathStp;
				isaPkg::add: begin
					w.alu = controlPkg::aluAdd;
					w.bus = controlPkg::busAddr;
				end
				isaPkg::mul1: begin
					w.alu = controlPkg::aluMul;
					w.bus = controlPkg::busMulr;
				end
				isaPkg::mul2: begin
					w.alu = controlPkg::aluMul;
					w.bus = controlPkg::busMv;
				end
				isaPkg::div: begin
					w.alu = controlPkg::aluDiv;
					w.bus = controlPkg::busWv;
				end
				isaPkg::mod: begin
					w.alu = controlPkg::aluMod;
					w.bus = controlPkg::busWv;
				end
				default: ;
			endcase
		end else begin
			case (op)
				isaPkg::ldAddr1: begin
					w.bus = controlPkg::busMemOut;
					w.wr = maskOf(controlPkg::regAddr);
				end
				isaPkg::ldAc1, isaPkg::ldCp1: begin
					w.bus = controlPkg::busMemOut;
					w.wr = maskOf(controlPkg::regAc);
				end
				isaPkg::ldMulr1, isaPkg::ldRp1: begin
					w.bus = controlPkg::busMemOut;
					w.wr = maskOf(controlPkg::regMulr);
				end
				isaPkg::store: begin
					w.path = controlPkg::pathStp;
					w.mem = controlPkg::memWrite;
				end
				isaPkg::jmpZ1, isaPkg::jmpZ2: begin
					if (isTaken && n == 3) begin
						w.wr = maskOf(controlPkg::regIr);
					end else if (isTaken && n == 4) begin
						w.wr = maskOf(controlPkg::regPc);
					end else if (!isTaken && n == 3) begin
						w.inc = maskOf(controlPkg::regPc);
						w.wr = maskOf(controlPkg::regIr);
					end
				end
				isaPkg::jump1: begin
					if (n == 4) begin
						w.wr = maskOf(controlPkg::regPc);
					end
				end
				default: ;
			endcase
		end
		return w;
	endfunction

	// Reference model, one step per clock; its word lands one cycle later like the DUT's
	always @(posedge clk) begin
		checkIndex <= testIndex;
		if (reset) begin
			step <= 0;
			taken <= 1'b0;
			want <= idleWord;
		end else begin
			want <= wordFor(curOp, step, taken);
			if (step == 0) begin
				step <= 1;
			end else if (step == 1) begin
				curOp <= instruction;
				// Unknown bytes are only the fetch pair long
				step <= (instrLength(instruction, 1'b0) == 2) ? 0 : 2;
			end else if (curOp != isaPkg::endOp) begin
				if (step == 2) begin
					taken <= (curOp == isaPkg::jmpZ1) ? zeroFlag1 : !zeroFlag2;
				end
				step <= (step + 1 == instrLength(curOp, taken)) ? 0 : step + 1;
			end
		end
	end

	aluCheck: assert property (@(posedge clk) disable iff (reset) aluOp == want.alu)
		else noteMismatch("aluOp", $sampled(checkIndex),
			32'($sampled(want.alu)), 32'($sampled(aluOp)));
	busCheck: assert property (@(posedge clk) disable iff (reset) busSelect == want.bus)
		else noteMismatch("busSelect", $sampled(checkIndex),
			32'($sampled(want.bus)), 32'($sampled(busSelect)));
	pathCheck: assert property (@(posedge clk) disable iff (reset) addressPath == want.path)
		else noteMismatch("addressPath", $sampled(checkIndex),
			32'($sampled(want.path)), 32'($sampled(addressPath)));
	memCheck: assert property (@(posedge clk) disable iff (reset) memControl == want.mem)
		else noteMismatch("memControl", $sampled(checkIndex),
			32'($sampled(want.mem)), 32'($sampled(memControl)));
	writeCheck: assert property (@(posedge clk) disable iff (reset) writeEnable == want.wr)
		else noteMismatch("writeEnable", $sampled(checkIndex),
			32'($sampled(want.wr)), 32'($sampled(writeEnable)));
	incCheck: assert property (@(posedge clk) disable iff (reset) incrementEnable == want.inc)
		else noteMismatch("incrementEnable", $sampled(checkIndex),
			32'($sampled(want.inc)), 32'($sampled(incrementEnable)));
	clearCheck: assert property (@(posedge clk) disable iff (reset) resetEnable == want.clr)
		else noteMismatch("resetEnable", $sampled(checkIndex),
			32'($sampled(want.clr)), 32'($sampled(resetEnable)));

	task automatic noteMismatch(input string field, input int idx,
			input logic [31:0] expected, input logic [31:0] actual);
		errorCount++;
		testErrors[idx]++;
		$display("** Error %s: %s expected %0h actual %0h", testNames[idx], field,
			expected, actual);
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// Byte and flags stay put over the whole instruction
	task automatic runInstr(input isaPkg::opcodeT op, input bit z1, input bit z2);
		bit isTaken;
		isTaken = (op == isaPkg::jmpZ1) ? z1 : !z2;
		instruction = op;
		zeroFlag1 = z1;
		zeroFlag2 = z2;
		waitCycles(instrLength(op, isTaken));
	endtask

	task automatic runPlain(input isaPkg::opcodeT op);
		runInstr(op, 1'($urandom), 1'($urandom));
	endtask

	// Last word of a test is checked one edge after its window closes
	task automatic reportAfterDrain(input int idx);
		@(posedge clk);
		#1;
		$display("%s: finished with %0d mismatches", testNames[idx], testErrors[idx]);
	endtask

	task automatic finishTest();
		int idx;
		idx = testIndex;
		fork
			reportAfterDrain(idx);
		join_none
	endtask

	initial begin
		void'($urandom(59));
		instruction = 8'($urandom);
		zeroFlag1 = 1'b0;
		zeroFlag2 = 1'b0;
		@(negedge reset);

		runPlain(isaPkg::incAc);
		finishTest();

		// Opcodes of each group are contiguous in isaPkg
		testIndex = 1;
		for (int op = int'(isaPkg::rstAll); op <= int'(isaPkg::incStp); op++) begin
			runPlain(isaPkg::opcodeT'(op));
		end
		finishTest();

		testIndex = 2;
		for (int op = int'(isaPkg::ldAddr1); op <= int'(isaPkg::store); op++) begin
			runPlain(isaPkg::opcodeT'(op));
		end
		finishTest();

		testIndex = 3;
		for (int op = int'(isaPkg::add); op <= int'(isaPkg::mod); op++) begin
			runPlain(isaPkg::opcodeT'(op));
		end
		finishTest();

		testIndex = 4;
		runInstr(isaPkg::jmpZ1, 1'b1, 1'($urandom));
		runInstr(isaPkg::jmpZ1, 1'b0, 1'($urandom));
		runInstr(isaPkg::jmpZ2, 1'($urandom), 1'b0);
		runInstr(isaPkg::jmpZ2, 1'($urandom), 1'b1);
		runPlain(isaPkg::jump1);
		finishTest();

		// Halted sequencer must ignore every byte that follows
		testIndex = 5;
		runPlain(8'h7f);
		instruction = isaPkg::endOp;
		waitCycles(2);
		repeat (10) begin
			instruction = 8'($urandom);
			waitCycles(1);
		end
		finishTest();

		waitCycles(2);
		$display("Tests run: 6, mismatches: %0d", errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display("Errors found");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
hw/isaPkg.sv
hw/controlPkg.sv
hw/stateSequencer.sv
hw/controlDecoder.sv
hw/controlUnit.sv
verification/clockGen.sv
verification/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module controlUnitTb -f sources.f -o controlUnitSim
output=$(./obj_dir/controlUnitSim)
echo "$output"
if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1
